/* hw/fb_ctrl.sv */
`timescale 1ns/1ps

module fb_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       h_visible,
    input  logic       v_visible,
    input  logic       fetch_slot,
    input  logic       frame_start,
    input  logic       write_mode,
    input  logic       write_req,
    input  logic       ptr_rst,
    input  logic [3:0] write_nibble,
    output logic       write_ack,
    output logic       write_ready,
    output logic       fetch_valid,
    output logic [7:0] ram_dir,
    output logic [7:0] ram_dout
);
    import vga_pkg::*;

    localparam int TW = $clog2(TURNAROUND);

    logic [1:0]    state;
    logic [TW-1:0] turn_cnt;
    logic          read_strobe;
    logic          write_bit;
    logic          data_drive;
    logic          strobe;
    logic          ptr_bit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_READ;
            turn_cnt    <= '0;
            read_strobe <= 1'b0;
            fetch_valid <= 1'b0;
            write_ack   <= 1'b0;
        end else begin
            read_strobe <= 1'b0;
            fetch_valid <= read_strobe;  // ram registers the nibble on the strobe clock

            if (!write_req) begin
                write_ack <= 1'b0;  // phase four of the handshake
            end

            case (state)
                ST_READ: begin
                    if (write_mode) begin
                        state    <= ST_TURN;
                        // the entry clock counts as the first turnaround cycle
                        turn_cnt <= TW'(TURNAROUND - 2);
                    end else begin
                        read_strobe <= fetch_slot && h_visible && v_visible;
                    end
                end

                ST_TURN: begin
                    if (!write_mode) begin
                        state <= ST_READ;
                    end else if (turn_cnt == '0) begin
                        state <= ST_WIDLE;
                    end else begin
                        turn_cnt <= turn_cnt - 1'b1;
                    end
                end

                ST_WIDLE: begin
                    if (!write_mode) begin
                        state <= ST_READ;  // fetches pick up at the next slot
                    end else if (write_req && !write_ack) begin
                        state <= ST_WSTROBE;
                    end
                end

                ST_WSTROBE: begin
                    write_ack <= 1'b1;
                    state     <= write_mode ? ST_WIDLE : ST_READ;
                end

                default: begin
                    state <= ST_READ;
                end
            endcase
        end
    end

    assign write_bit   = (state != ST_READ);
    assign data_drive  = (state == ST_WIDLE) || (state == ST_WSTROBE);
    assign write_ready = data_drive;
    assign strobe      = read_strobe || (state == ST_WSTROBE);

    // pointer restarts with each frame, or on host request in write mode
    assign ptr_bit = write_bit ? ptr_rst : frame_start;

    // control pins always out, data pins only once the bus has turned
    assign ram_dir = {4'hf, {4{data_drive}}};

    always_comb begin
        ram_dout              = 8'h00;
        ram_dout[3:0]         = write_nibble;
        ram_dout[BIT_WRITE]   = write_bit;
        ram_dout[BIT_PTR_RST] = ptr_bit;
        ram_dout[BIT_STROBE]  = strobe;
    end

endmodule

/* hw/pixel_pipe.sv */
`timescale 1ns/1ps

module pixel_pipe (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] ram_din,
    input  logic       fetch_valid,
    input  logic       h_sync,
    input  logic       v_sync,
    input  logic       h_visible,
    input  logic       v_visible,
    input  logic       write_ready,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [3:0] gray
);
    import vga_pkg::*;

    localparam int HW = $clog2(PIXEL_DIV + 1);

    logic [PIPE_DELAY-1:0] hsync_dly;
    logic [PIPE_DELAY-1:0] vsync_dly;
    logic [PIPE_DELAY-1:0] de_dly;
    logic [3:0]            pixel;
    logic [HW-1:0]         hold_cnt;

    // syncs and enable ride alongside the fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_dly <= '0;
            vsync_dly <= '0;
            de_dly    <= '0;
        end else begin
            hsync_dly <= {hsync_dly[PIPE_DELAY-2:0], h_sync};
            vsync_dly <= {vsync_dly[PIPE_DELAY-2:0], v_sync};
            de_dly    <= {de_dly[PIPE_DELAY-2:0], h_visible && v_visible};
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pixel <= ram_din[3:0];
        end
    end

    // each nibble is good for PIXEL_DIV clocks, then goes stale
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (fetch_valid) begin
            hold_cnt <= HW'(PIXEL_DIV);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign hsync = hsync_dly[PIPE_DELAY-1];
    assign vsync = vsync_dly[PIPE_DELAY-1];
    assign de    = de_dly[PIPE_DELAY-1];

    // black outside the picture, during turnaround and in write mode
    assign gray = (de && (hold_cnt != '0) && !write_ready) ? pixel : 4'h0;

endmodule

/* hw/vga_fb_top.sv */
`timescale 1ns/1ps

module vga_fb_top #(
    parameter int H_VISIBLE = vga_pkg::H_VISIBLE,
    parameter int H_FRONT   = vga_pkg::H_FRONT,
    parameter int H_SYNC    = vga_pkg::H_SYNC,
    parameter int H_BACK    = vga_pkg::H_BACK,
    parameter int V_VISIBLE = vga_pkg::V_VISIBLE,
    parameter int V_FRONT   = vga_pkg::V_FRONT,
    parameter int V_SYNC    = vga_pkg::V_SYNC,
    parameter int V_BACK    = vga_pkg::V_BACK
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       write_mode,
    input  logic       write_req,
    input  logic       ptr_rst,
    input  logic [3:0] write_nibble,
    input  logic [7:0] ram_din,
    output logic       write_ack,
    output logic       write_ready,
    output logic [7:0] ram_dir,
    output logic [7:0] ram_dout,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [3:0] gray
);

    logic h_sync;
    logic v_sync;
    logic h_visible;
    logic v_visible;
    logic fetch_slot;
    logic frame_start;
    logic fetch_valid;

    vga_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) timing_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .h_visible   (h_visible),
        .v_visible   (v_visible),
        .fetch_slot  (fetch_slot),
        .frame_start (frame_start)
    );

    fb_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .h_visible    (h_visible),
        .v_visible    (v_visible),
        .fetch_slot   (fetch_slot),
        .frame_start  (frame_start),
        .write_mode   (write_mode),
        .write_req    (write_req),
        .ptr_rst      (ptr_rst),
        .write_nibble (write_nibble),
        .write_ack    (write_ack),
        .write_ready  (write_ready),
        .fetch_valid  (fetch_valid),
        .ram_dir      (ram_dir),
        .ram_dout     (ram_dout)
    );

    // nibble comes back on ram_din two clocks after the slot
    pixel_pipe pipe_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ram_din     (ram_din),
        .fetch_valid (fetch_valid),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .h_visible   (h_visible),
        .v_visible   (v_visible),
        .write_ready (write_ready),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .gray        (gray)
    );

endmodule

/* hw/vga_pkg.sv */
package vga_pkg;

    // default 640x480 line timing, in pixel clocks
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;

    // default frame timing, in lines
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;

    localparam int PIXEL_DIV  = 2;   // clocks each fetched nibble stays on screen
    localparam int TURNAROUND = 16;  // bus settle time before the first write
    localparam int PIPE_DELAY = 3;   // fetch slot to gray, in clocks

    // control bits on the pin bus
    // bit 4 is spare, bits 3..0 carry the nibble
    localparam int BIT_WRITE   = 7;
    localparam int BIT_PTR_RST = 6;
    localparam int BIT_STROBE  = 5;

    // framebuffer controller states
    localparam logic [1:0] ST_READ    = 2'd0;  // display fetches
    localparam logic [1:0] ST_TURN    = 2'd1;  // bus turnaround
    localparam logic [1:0] ST_WIDLE   = 2'd2;  // write mode, waiting for host
    localparam logic [1:0] ST_WSTROBE = 2'd3;  // single write strobe

endpackage

/* hw/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_VISIBLE = vga_pkg::H_VISIBLE,
    parameter int H_FRONT   = vga_pkg::H_FRONT,
    parameter int H_SYNC    = vga_pkg::H_SYNC,
    parameter int H_BACK    = vga_pkg::H_BACK,
    parameter int V_VISIBLE = vga_pkg::V_VISIBLE,
    parameter int V_FRONT   = vga_pkg::V_FRONT,
    parameter int V_SYNC    = vga_pkg::V_SYNC,
    parameter int V_BACK    = vga_pkg::V_BACK
) (
    input  logic clk,
    input  logic rst_n,
    output logic h_sync,
    output logic v_sync,
    output logic h_visible,
    output logic v_visible,
    output logic fetch_slot,
    output logic frame_start
);
    import vga_pkg::*;

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int PW      = $clog2(H_TOTAL);
    localparam int LW      = $clog2(V_TOTAL);

    logic [PW-1:0] pixel_cnt;
    logic [LW-1:0] line_cnt;
    logic          line_step;
    logic          pixel_even;

    // line count moves one pixel early so the registered flags line up
    assign line_step  = (pixel_cnt == PW'(H_TOTAL - 2));
    assign pixel_even = ((pixel_cnt % PW'(PIXEL_DIV)) == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_cnt <= '0;
        end else if (pixel_cnt == PW'(H_TOTAL - 1)) begin
            pixel_cnt <= '0;
        end else begin
            pixel_cnt <= pixel_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_cnt <= '0;
        end else if (line_step) begin
            if (line_cnt == LW'(V_TOTAL - 1)) begin
                line_cnt <= '0;
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // all outputs one clock behind the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_sync      <= 1'b0;
            v_sync      <= 1'b0;
            h_visible   <= 1'b0;
            v_visible   <= 1'b0;
            fetch_slot  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            h_visible   <= (pixel_cnt < PW'(H_VISIBLE));
            v_visible   <= (line_cnt < LW'(V_VISIBLE));
            h_sync      <= (pixel_cnt >= PW'(H_VISIBLE + H_FRONT)) &&
                           (pixel_cnt < PW'(H_VISIBLE + H_FRONT + H_SYNC));
            v_sync      <= (line_cnt >= LW'(V_VISIBLE + V_FRONT)) &&
                           (line_cnt < LW'(V_VISIBLE + V_FRONT + V_SYNC));
            // one fetch per nibble, the pipe delay is matched downstream
            fetch_slot  <= pixel_even && (pixel_cnt < PW'(H_VISIBLE)) &&
                           (line_cnt < LW'(V_VISIBLE));
            frame_start <= (pixel_cnt == '0) && (line_cnt == '0);
        end
    end

endmodule

/* verif/fb_ram_model.sv */
`timescale 1ns/1ps

module fb_ram_model (
    input  logic       clk,
    input  logic [7:0] ram_dir,
    input  logic [7:0] ram_dout,
    output logic [7:0] ram_din
);
    import vga_pkg::*;

    logic [3:0] mem [256];
    logic [7:0] ptr;
    logic [3:0] bus_nibble;

    // undriven data pins float
    assign bus_nibble = (ram_dir[3:0] == 4'hf) ? ram_dout[3:0] : 4'hx;

    initial begin
        ptr     = '0;
        ram_din = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 4'(a >> 4) ^ 4'(a);  // power-up contents
        end
    end

    always @(posedge clk) begin
        if (ram_dout[BIT_STROBE] === 1'b1) begin
            if (ram_dout[BIT_WRITE]) begin
                mem[ptr] <= bus_nibble;
            end else begin
                ram_din <= {4'h0, mem[ptr]};  // read data registered on the strobe
            end
            ptr <= ptr + 1'b1;
        end
        if (ram_dout[BIT_PTR_RST] === 1'b1) begin
            ptr <= '0;  // wins over the advance
        end
    end

endmodule

/* verif/tb_vga_fb.sv */
`timescale 1ns/1ps

module tb_vga_fb;
    import vga_pkg::*;

    // small screen so a frame is 112 clocks
    localparam int H_VIS = 8;
    localparam int H_FP  = 2;
    localparam int H_SW  = 3;
    localparam int H_BP  = 3;
    localparam int V_VIS = 4;
    localparam int V_FP  = 1;
    localparam int V_SW  = 1;
    localparam int V_BP  = 1;
    localparam int H_TOT = H_VIS + H_FP + H_SW + H_BP;
    localparam int V_TOT = V_VIS + V_FP + V_SW + V_BP;
    localparam int DRIVE_DLY  = 1;
    localparam int WAIT_LIMIT = 64;
    localparam int BURSTS     = 8;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       write_mode;
    logic       write_req;
    logic       ptr_rst;
    logic [3:0] write_nibble;
    logic [7:0] ram_din;
    logic       write_ack;
    logic       write_ready;
    logic [7:0] ram_dir;
    logic [7:0] ram_dout;
    logic       hsync;
    logic       vsync;
    logic       de;
    logic [3:0] gray;

    logic [31:0] lfsr = 32'h93c7_d941;
    logic [3:0]  shadow [256];  // expected framebuffer
    logic [7:0]  shadow_ptr;
    int nibble_errs = 0;
    int flag_errs   = 0;
    int count_errs  = 0;
    int other_errs  = 0;
    int cyc = 0;
    int hs_rise = -1;
    int vs_rise = -1;
    int line_idx = 0;
    int px_idx = 0;
    int wm_cnt = 0;
    int frames = 0;
    int pix_checked = 0;
    logic clean = 1'b0;  // frame began in read mode
    logic prev_hs = 1'b0;
    logic prev_vs = 1'b0;
    logic prev_de = 1'b0;

    always #50 clk = ~clk;

    vga_fb_top #(
        .H_VISIBLE (H_VIS),
        .H_FRONT   (H_FP),
        .H_SYNC    (H_SW),
        .H_BACK    (H_BP),
        .V_VISIBLE (V_VIS),
        .V_FRONT   (V_FP),
        .V_SYNC    (V_SW),
        .V_BACK    (V_BP)
    ) vga_fb_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_mode   (write_mode),
        .write_req    (write_req),
        .ptr_rst      (ptr_rst),
        .write_nibble (write_nibble),
        .ram_din      (ram_din),
        .write_ack    (write_ack),
        .write_ready  (write_ready),
        .ram_dir      (ram_dir),
        .ram_dout     (ram_dout),
        .hsync        (hsync),
        .vsync        (vsync),
        .de           (de),
        .gray         (gray)
    );

    fb_ram_model ram_i (
        .clk      (clk),
        .ram_dir  (ram_dir),
        .ram_dout (ram_dout),
        .ram_din  (ram_din)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_nibble(input string what, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            nibble_errs++;
            $display("Error at %0t: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("Error at %0t: %s expected %b got %b", $time, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            count_errs++;
            $display("Error at %0t: %s expected %0d got %0d", $time, what, exp, act);
        end
    endtask

    function automatic int total_errs();
        return nibble_errs + flag_errs + count_errs + other_errs
            + vga_fb_top_i.ctrl_i.asserts_i.fail_cnt;
    endfunction

    task automatic print_counts();
        $display("errors: gray %0d, flags %0d, timing %0d, other %0d, assertions %0d",
                 nibble_errs, flag_errs, count_errs, other_errs,
                 vga_fb_top_i.ctrl_i.asserts_i.fail_cnt);
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout: %s", what);
        print_counts();
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // n counts rising edges until the level shows
    task automatic wait_level(input bit on_ready, input logic level, output int n);
        logic sig;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
            sig = on_ready ? write_ready : write_ack;
        end while (sig !== level && n < WAIT_LIMIT);
        if (sig !== level) begin
            timeout_abort($sformatf("%s never reached %b", on_ready ? "write_ready" : "write_ack",
                                    level));
        end
    endtask

    task automatic wait_frames(input int k);
        int target;
        int n;
        target = frames + k;
        n = 0;
        while (frames < target && n < (k + 1) * H_TOT * V_TOT) begin
            @(posedge clk);
            n++;
        end
        if (frames < target) begin
            timeout_abort("no vertical sync seen within the expected frames");
        end
        #DRIVE_DLY;
    endtask

    task automatic pulse_ptr_rst();
        ptr_rst = 1'b1;
        next_cycle();
        ptr_rst = 1'b0;
        shadow_ptr = '0;
        check_count("ram pointer after ptr_rst", 0, int'(ram_i.ptr));
    endtask

    task automatic host_write(input logic [3:0] nib);
        int n;
        int hold;
        write_nibble = nib;
        write_req = 1'b1;
        wait_level(1'b0, 1'b1, n);
        check_count("write_ack rise delay", 2, n);
        shadow[shadow_ptr] = nib;
        check_nibble($sformatf("ram[%0d]", shadow_ptr), nib, ram_i.mem[shadow_ptr]);
        shadow_ptr = shadow_ptr + 1'b1;
        check_count("ram pointer", int'(shadow_ptr), int'(ram_i.ptr));
        hold = rand_bits(2);  // host stalls before releasing
        repeat (hold) begin
            @(negedge clk);
            check_flag("write_ack", 1'b1, write_ack);
        end
        next_cycle();
        write_req = 1'b0;
        wait_level(1'b0, 1'b0, n);
        check_count("write_ack fall delay", 1, n);
        next_cycle();
    endtask

    task automatic write_burst(input int count, input bit rand_rst);
        int n;
        write_mode = 1'b1;
        wait_level(1'b1, 1'b1, n);
        check_count("write_ready delay", TURNAROUND, n);
        next_cycle();
        pulse_ptr_rst();
        for (int i = 0; i < count; i++) begin
            if (rand_rst && rand_bits(3) == 0) begin
                pulse_ptr_rst();
            end
            host_write(4'(rand_bits(4)));
        end
        write_mode = 1'b0;
        wait_level(1'b1, 1'b0, n);
        check_count("write_ready fall delay", 1, n);
        next_cycle();
    endtask

    // output monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            cyc++;
            if (write_mode) begin
                clean = 1'b0;
                wm_cnt++;
            end else begin
                wm_cnt = 0;
            end
            if (hsync && !prev_hs) begin
                if (hs_rise >= 0) check_count("hsync period", H_TOT, cyc - hs_rise);
                hs_rise = cyc;
            end
            if (!hsync && prev_hs) check_count("hsync width", H_SW, cyc - hs_rise);
            // sync and back porch sit between hsync rise and the next line
            if (de && !prev_de && hs_rise >= 0) begin
                check_count("hsync rise to de rise", H_SW + H_BP, cyc - hs_rise);
            end
            if (vsync && !prev_vs) begin
                if (vs_rise >= 0) begin
                    check_count("vsync period", H_TOT * V_TOT, cyc - vs_rise);
                    check_count("de lines per frame", V_VIS, line_idx);
                end
                vs_rise = cyc;
                line_idx = 0;  // next frame reads from entry 0
                clean = !write_mode;
                frames++;
            end
            if (!vsync && prev_vs) check_count("vsync width", H_TOT * V_SW, cyc - vs_rise);
            if (de) begin
                if (clean) begin
                    check_nibble("gray", shadow[line_idx * (H_VIS / PIXEL_DIV)
                                                + px_idx / PIXEL_DIV], gray);
                    pix_checked++;
                end
                px_idx++;
            end else begin
                check_nibble("gray outside de", 4'h0, gray);
            end
            if (!de && prev_de) begin
                check_count("de run length", H_VIS, px_idx);
                px_idx = 0;
                line_idx++;
            end
            // pixels already in the pipe drain first
            if (write_ready || wm_cnt >= PIPE_DELAY + PIXEL_DIV) begin
                check_nibble("gray in write mode", 4'h0, gray);
            end
            prev_hs = hsync;
            prev_vs = vsync;
            prev_de = de;
        end
    end

    initial begin
        int idle;
        $timeformat(-9, 0, " ns", 0);
        rst_n        = 1'b0;
        write_mode   = 1'b0;
        write_req    = 1'b0;
        ptr_rst      = 1'b0;
        write_nibble = 4'h0;
        shadow_ptr   = '0;
        for (int a = 0; a < 256; a++) begin
            shadow[a] = 4'(a >> 4) ^ 4'(a);
        end
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        wait_frames(3);  // two full frames of power-up contents
        write_burst(H_VIS * V_VIS / PIXEL_DIV, 1'b0);
        wait_frames(2);
        for (int b = 0; b < BURSTS; b++) begin
            wait_frames(1);
            idle = rand_bits(5);  // start somewhere in the blanking
            repeat (idle) next_cycle();
            write_burst(2 + rand_bits(3), 1'b1);
            wait_frames(2);
        end
        if (pix_checked == 0) begin
            other_errs++;
            $display("no pixel was compared during read mode frames");
        end
        print_counts();
        if (total_errs() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/vga_fb_asserts.sv */
`timescale 1ns/1ps

module vga_fb_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       write_req,
    input logic       write_ack,
    input logic [7:0] ram_dir,
    input logic [7:0] ram_dout
);
    import vga_pkg::*;

    int fail_cnt = 0;  // tally of failed properties

    // data pins turn only after the write bit has been up for a full turnaround
    dir_follows_write: assert property (@(posedge clk) disable iff (!rst_n)
        (ram_dir[3:0] != 4'h0) |->
            ram_dout[BIT_WRITE] && $past(ram_dout[BIT_WRITE], TURNAROUND - 1))
    else begin
        fail_cnt++;
        $error("data pins driven without a full turnaround under the write bit");
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(write_ack) |-> $past(write_req))
    else begin
        fail_cnt++;
        $error("write_ack rose without write_req");
    end

    no_strobe_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(ram_dout[BIT_STROBE] && write_ack))
    else begin
        fail_cnt++;
        $error("strobe issued while write_ack is high");
    end

    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (write_ack && write_req) |=> write_ack)
    else begin
        fail_cnt++;
        $error("write_ack dropped before write_req");
    end

endmodule

bind fb_ctrl vga_fb_asserts asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .write_req (write_req),
    .write_ack (write_ack),
    .ram_dir   (ram_dir),
    .ram_dout  (ram_dout)
);

/* vlog.f */
hw/vga_pkg.sv
hw/vga_timing.sv
hw/fb_ctrl.sv
hw/pixel_pipe.sv
hw/vga_fb_top.sv
verif/fb_ram_model.sv
verif/vga_fb_asserts.sv
verif/tb_vga_fb.sv
